/* Bender.yml */
package:
  name: div_rs

sources:
  - files:
      - logic/rs_types_pkg.sv
      - logic/rs_config_pkg.sv
      - logic/rs_dispatch_if.sv
      - logic/rs_wakeup_if.sv
      - logic/rs_dispatch.sv
      - logic/rs_entry_array.sv
      - logic/rs_issue_select.sv
      - logic/div_rs_top.sv
  - target: simulation
    files:
      - verification/div_rs_tb.sv

/* files.f */
logic/rs_types_pkg.sv
logic/rs_config_pkg.sv
logic/rs_dispatch_if.sv
logic/rs_wakeup_if.sv
logic/rs_dispatch.sv
logic/rs_entry_array.sv
logic/rs_issue_select.sv
logic/div_rs_top.sv
verification/div_rs_tb.sv

/* logic/div_rs_top.sv */
`timescale 1ns/1ps

module div_rs_top import rs_types_pkg::*, rs_config_pkg::*; #(
    parameter int RS_DEPTH      = RS_DEPTH_DEFAULT,
    parameter int SELECT_WINDOW = SELECT_WINDOW_DEFAULT
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      dispatch_valid,
    input  pc_t       dispatch_pc,
    input  phys_reg_t dispatch_rd,
    input  alu_op_t   dispatch_op,
    input  phys_reg_t dispatch_src1,
    input  phys_reg_t dispatch_src2,
    input  logic      dispatch_ready1,
    input  logic      dispatch_ready2,
    input  logic      alu_result_valid,
    input  phys_reg_t alu_result_dest,
    input  logic      mul_result_valid,
    input  phys_reg_t mul_result_dest,
    input  logic      div_result_valid,
    input  phys_reg_t div_result_dest,
    input  logic      load_read,
    input  phys_reg_t load_dest,
    output logic      issue_valid,
    output pc_t       issue_pc,
    output phys_reg_t issue_rd,
    output alu_op_t   issue_op,
    output phys_reg_t issue_src1,
    output phys_reg_t issue_src2
);

    localparam int IDX_W = $clog2(RS_DEPTH);

    logic                head_advance;
    logic [IDX_W-1:0]    head_index;
    logic                grant;
    logic [IDX_W-1:0]    grant_index;
    logic [IDX_W-1:0]    read_index;
    logic [RS_DEPTH-1:0] ready_vec;
    logic [RS_DEPTH-1:0] issued_vec;
    pc_t                 read_pc;
    phys_reg_t           read_rd;
    alu_op_t             read_op;
    phys_reg_t           read_src1;
    phys_reg_t           read_src2;

    rs_wakeup_if wake ();
    rs_dispatch_if #(.RS_DEPTH(RS_DEPTH)) disp ();

    assign wake.wake_valid[WAKE_ALU]  = alu_result_valid;
    assign wake.wake_tag[WAKE_ALU]    = alu_result_dest;
    assign wake.wake_valid[WAKE_MUL]  = mul_result_valid;
    assign wake.wake_tag[WAKE_MUL]    = mul_result_dest;
    assign wake.wake_valid[WAKE_DIV]  = div_result_valid;
    assign wake.wake_tag[WAKE_DIV]    = div_result_dest;
    assign wake.wake_valid[WAKE_LOAD] = load_read;     // Load data returning
    assign wake.wake_tag[WAKE_LOAD]   = load_dest;

    rs_dispatch #(.RS_DEPTH(RS_DEPTH)) rs_dispatch_inst (
        .clk(clk), .reset(reset),
        .dispatch_valid(dispatch_valid), .dispatch_pc(dispatch_pc),
        .dispatch_rd(dispatch_rd), .dispatch_op(dispatch_op),
        .dispatch_src1(dispatch_src1), .dispatch_src2(dispatch_src2),
        .dispatch_ready1(dispatch_ready1), .dispatch_ready2(dispatch_ready2),
        .wake(wake.observer), .head_advance(head_advance), .disp(disp.sender)
    );

    rs_entry_array #(.RS_DEPTH(RS_DEPTH), .SELECT_WINDOW(SELECT_WINDOW)) rs_entry_array_inst (
        .clk(clk), .reset(reset), .disp(disp.receiver), .wake(wake.observer),
        .grant(grant), .grant_index(grant_index),
        .head_advance(head_advance), .head_index(head_index),
        .ready_vec(ready_vec), .issued_vec(issued_vec), .read_index(read_index),
        .read_pc(read_pc), .read_rd(read_rd), .read_op(read_op),
        .read_src1(read_src1), .read_src2(read_src2)
    );

    rs_issue_select #(.RS_DEPTH(RS_DEPTH), .SELECT_WINDOW(SELECT_WINDOW)) rs_issue_select_inst (
        .clk(clk), .reset(reset), .ready_vec(ready_vec), .issued_vec(issued_vec),
        .read_pc(read_pc), .read_rd(read_rd), .read_op(read_op),
        .read_src1(read_src1), .read_src2(read_src2), .read_index(read_index),
        .grant(grant), .grant_index(grant_index),
        .head_advance(head_advance), .head_index(head_index),
        .issue_valid(issue_valid), .issue_pc(issue_pc), .issue_rd(issue_rd),
        .issue_op(issue_op), .issue_src1(issue_src1), .issue_src2(issue_src2)
    );

endmodule

/* logic/rs_config_pkg.sv */
package rs_config_pkg;

    localparam int RS_DEPTH_DEFAULT      = 16;  // Power of two
    localparam int SELECT_WINDOW_DEFAULT = 8;   // Entries searched from the head

    // Result broadcasts that can wake a waiting operand
    localparam int N_WAKE    = 4;
    localparam int WAKE_ALU  = 0;
    localparam int WAKE_MUL  = 1;
    localparam int WAKE_DIV  = 2;
    localparam int WAKE_LOAD = 3;

endpackage

/* logic/rs_dispatch.sv */
`timescale 1ns/1ps

module rs_dispatch import rs_types_pkg::*, rs_config_pkg::*; #(
    parameter int RS_DEPTH = RS_DEPTH_DEFAULT
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          dispatch_valid,
    input  pc_t           dispatch_pc,
    input  phys_reg_t     dispatch_rd,
    input  alu_op_t       dispatch_op,
    input  phys_reg_t     dispatch_src1,
    input  phys_reg_t     dispatch_src2,
    input  logic          dispatch_ready1,
    input  logic          dispatch_ready2,
    rs_wakeup_if.observer wake,
    input  logic          head_advance,
    rs_dispatch_if.sender disp
);

    localparam int IDX_W = $clog2(RS_DEPTH);

    logic [IDX_W-1:0] tail;
    logic [IDX_W:0]   count;    // Entries between head and tail
    logic             full;

    assign full = (count == (IDX_W+1)'(RS_DEPTH));

    always_ff @(posedge clk) begin
        if (reset) begin
            tail  <= '0;
            count <= '0;
        end else begin
            if (dispatch_valid) begin
                tail <= tail + 1'b1;    // Wraps with the power-of-two depth
            end
            count <= count + (IDX_W+1)'(dispatch_valid) - (IDX_W+1)'(head_advance);
        end
    end

    assign disp.write = dispatch_valid;
    assign disp.index = tail;
    assign disp.pc    = dispatch_pc;
    assign disp.rd    = dispatch_rd;
    assign disp.op    = dispatch_op;
    assign disp.src1  = dispatch_src1;
    assign disp.src2  = dispatch_src2;

    // A result on any bus this cycle counts as already written back
    assign disp.ready1 = dispatch_ready1 | wake.tag_hit(dispatch_src1);
    assign disp.ready2 = dispatch_ready2 | wake.tag_hit(dispatch_src2);

    // Occupancy follows head moves made in the select logic
    assert property (@(posedge clk) disable iff (reset) dispatch_valid |-> !full)
        else $error("Dispatch into a full reservation station");

endmodule

/* logic/rs_dispatch_if.sv */
`timescale 1ns/1ps

interface rs_dispatch_if import rs_types_pkg::*, rs_config_pkg::*; #(
    parameter int RS_DEPTH = RS_DEPTH_DEFAULT
) ();

    localparam int IDX_W = $clog2(RS_DEPTH);

    logic             write;    // One cycle per instruction
    logic [IDX_W-1:0] index;    // Tail slot
    pc_t              pc;
    phys_reg_t        rd;
    alu_op_t          op;
    phys_reg_t        src1;
    phys_reg_t        src2;
    logic             ready1;   // Includes same-cycle bypass
    logic             ready2;

    modport sender (
        output write, index, pc, rd, op, src1, src2, ready1, ready2
    );

    modport receiver (
        input write, index, pc, rd, op, src1, src2, ready1, ready2
    );

endinterface

/* logic/rs_entry_array.sv */
`timescale 1ns/1ps

module rs_entry_array import rs_types_pkg::*, rs_config_pkg::*; #(
    parameter int RS_DEPTH      = RS_DEPTH_DEFAULT,
    parameter int SELECT_WINDOW = SELECT_WINDOW_DEFAULT,
    localparam int IDX_W        = $clog2(RS_DEPTH)
) (
    input  logic                   clk,
    input  logic                   reset,
    rs_dispatch_if.receiver        disp,
    rs_wakeup_if.observer          wake,
    input  logic                   grant,
    input  logic [IDX_W-1:0]       grant_index,
    input  logic                   head_advance,
    input  logic [IDX_W-1:0]       head_index,
    output logic [RS_DEPTH-1:0]    ready_vec,
    output logic [RS_DEPTH-1:0]    issued_vec,
    input  logic [IDX_W-1:0]       read_index,
    output pc_t                    read_pc,
    output phys_reg_t              read_rd,
    output alu_op_t                read_op,
    output phys_reg_t              read_src1,
    output phys_reg_t              read_src2
);

    if (RS_DEPTH != (1 << IDX_W)) begin : g_depth_check
        $error("Station depth must be a power of two");
    end

    if (SELECT_WINDOW > RS_DEPTH) begin : g_window_check
        $error("Select window wider than the station");
    end

    pc_t       pc_q   [RS_DEPTH];
    phys_reg_t rd_q   [RS_DEPTH];
    alu_op_t   op_q   [RS_DEPTH];
    phys_reg_t src1_q [RS_DEPTH];
    phys_reg_t src2_q [RS_DEPTH];

    logic [RS_DEPTH-1:0] occupied;  // Holds an instruction the head has not passed
    logic [RS_DEPTH-1:0] issued;    // Left the station out of order
    logic [RS_DEPTH-1:0] ready1;
    logic [RS_DEPTH-1:0] ready2;

    always_ff @(posedge clk) begin
        if (disp.write) begin
            pc_q[disp.index]   <= disp.pc;
            rd_q[disp.index]   <= disp.rd;
            op_q[disp.index]   <= disp.op;
            src1_q[disp.index] <= disp.src1;
            src2_q[disp.index] <= disp.src2;
        end
    end

    // Later statements win, so grant beats wakeup and release beats grant
    always_ff @(posedge clk) begin
        if (reset) begin
            occupied <= '0;
            issued   <= '0;
            ready1   <= '0;
            ready2   <= '0;
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (occupied[i] && !issued[i]) begin
                    if (!ready1[i] && wake.tag_hit(src1_q[i])) begin
                        ready1[i] <= 1'b1;
                    end
                    if (!ready2[i] && wake.tag_hit(src2_q[i])) begin
                        ready2[i] <= 1'b1;
                    end
                end
            end
            if (grant) begin
                ready1[grant_index] <= 1'b0;
                ready2[grant_index] <= 1'b0;
                issued[grant_index] <= 1'b1;
            end
            if (head_advance) begin
                occupied[head_index] <= 1'b0;
                issued[head_index]   <= 1'b0;
            end
            if (disp.write) begin
                occupied[disp.index] <= 1'b1;
                issued[disp.index]   <= 1'b0;
                ready1[disp.index]   <= disp.ready1;
                ready2[disp.index]   <= disp.ready2;
            end
        end
    end

    assign ready_vec  = occupied & ready1 & ready2;
    assign issued_vec = issued;

    assign read_pc   = pc_q[read_index];
    assign read_rd   = rd_q[read_index];
    assign read_op   = op_q[read_index];
    assign read_src1 = src1_q[read_index];
    assign read_src2 = src2_q[read_index];

    // Select only ever picks live entries
    assert property (@(posedge clk) disable iff (reset) grant |-> occupied[grant_index])
        else $error("Grant to an empty entry");

    // Tail must never catch up with an entry the head has not released
    assert property (@(posedge clk) disable iff (reset) disp.write |-> !occupied[disp.index])
        else $error("Dispatch over a live entry");

endmodule

/* logic/rs_issue_select.sv */
`timescale 1ns/1ps

module rs_issue_select import rs_types_pkg::*, rs_config_pkg::*; #(
    parameter int RS_DEPTH      = RS_DEPTH_DEFAULT,
    parameter int SELECT_WINDOW = SELECT_WINDOW_DEFAULT,
    localparam int IDX_W        = $clog2(RS_DEPTH)
) (
    input  logic                clk,
    input  logic                reset,
    input  logic [RS_DEPTH-1:0] ready_vec,
    input  logic [RS_DEPTH-1:0] issued_vec,
    input  pc_t                 read_pc,
    input  phys_reg_t           read_rd,
    input  alu_op_t             read_op,
    input  phys_reg_t           read_src1,
    input  phys_reg_t           read_src2,
    output logic [IDX_W-1:0]    read_index,
    output logic                grant,
    output logic [IDX_W-1:0]    grant_index,
    output logic                head_advance,
    output logic [IDX_W-1:0]    head_index,
    output logic                issue_valid,
    output pc_t                 issue_pc,
    output phys_reg_t           issue_rd,
    output alu_op_t             issue_op,
    output phys_reg_t           issue_src1,
    output phys_reg_t           issue_src2
);

    logic             found;
    logic [IDX_W-1:0] pick;

    // Oldest ready entry wins, counted from the head
    always_comb begin
        found = 1'b0;
        pick  = head_index;
        for (int k = 0; k < SELECT_WINDOW; k++) begin
            if (!found && ready_vec[IDX_W'(head_index + k)]) begin
                found = 1'b1;
                pick  = IDX_W'(head_index + k);
            end
        end
    end

    assign grant       = found;
    assign grant_index = pick;
    assign read_index  = pick;

    // Head leaves on its own grant or once it was issued out of order
    assign head_advance = (grant && (grant_index == head_index)) || issued_vec[head_index];

    always_ff @(posedge clk) begin
        if (reset) begin
            head_index <= '0;
        end else if (head_advance) begin
            head_index <= head_index + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= grant;   // Single cycle per grant
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            issue_pc   <= read_pc;
            issue_rd   <= read_rd;
            issue_op   <= read_op;
            issue_src1 <= read_src1;
            issue_src2 <= read_src2;
        end
    end

    // Granted entry has not left the station yet
    assert property (@(posedge clk) disable iff (reset)
        grant |-> !issued_vec[grant_index])
        else $error("Granted an entry that already issued");

endmodule

/* logic/rs_types_pkg.sv */
package rs_types_pkg;

    // Instruction address as seen by the divide unit
    typedef logic [31:0] pc_t;

    // Physical register tag
    // Also the tag that every result broadcast carries
    typedef logic [7:0] phys_reg_t;

    typedef logic [3:0] alu_op_t;   // Divide flavour

endpackage

/* logic/rs_wakeup_if.sv */
`timescale 1ns/1ps

interface rs_wakeup_if import rs_types_pkg::*, rs_config_pkg::*; ();

    logic [N_WAKE-1:0] wake_valid;
    phys_reg_t         wake_tag [N_WAKE];

    // True when any valid broadcast this cycle carries the tag
    function automatic logic tag_hit(input phys_reg_t tag);
        logic hit;
        hit = 1'b0;
        for (int b = 0; b < N_WAKE; b++) begin
            if (wake_valid[b] && (wake_tag[b] == tag)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    modport source (
        output wake_valid, wake_tag
    );

    modport observer (
        input wake_valid, wake_tag,
        import tag_hit
    );

endinterface

/* verification/div_rs_tb.sv */
`timescale 1ns/1ps

module div_rs_tb;
    import rs_types_pkg::*;

    localparam int DEPTH  = 16;
    localparam int WINDOW = 8;

    typedef struct {
        logic      dv;
        pc_t       pc;
        phys_reg_t rd;
        alu_op_t   op;
        phys_reg_t src1;
        phys_reg_t src2;
        logic      rdy1;
        logic      rdy2;
        int        bus;     // Which broadcast carries the tag
        logic      wv;
        phys_reg_t tag;
    } row_t;

    logic clk, reset;
    logic dispatch_valid, dispatch_ready1, dispatch_ready2;
    pc_t dispatch_pc;
    phys_reg_t dispatch_rd, dispatch_src1, dispatch_src2;
    alu_op_t dispatch_op;
    logic alu_result_valid, mul_result_valid, div_result_valid, load_read;
    phys_reg_t alu_result_dest, mul_result_dest, div_result_dest, load_dest;
    logic issue_valid;
    pc_t issue_pc;
    phys_reg_t issue_rd, issue_src1, issue_src2;
    alu_op_t issue_op;

    row_t  table_rows[$];
    string table_names[$];

    // Reference model state
    logic      m_occ[DEPTH], m_iss[DEPTH], m_r1[DEPTH], m_r2[DEPTH];
    pc_t       m_pc[DEPTH];
    phys_reg_t m_rd[DEPTH], m_src1[DEPTH], m_src2[DEPTH];
    alu_op_t   m_op[DEPTH];
    int        m_head, m_tail, m_count;
    logic      exp_valid;
    row_t      exp_pkt;

    int        disp_count, dut_issues, cycles, cycle_limit;

    div_rs_top #(.RS_DEPTH(DEPTH), .SELECT_WINDOW(WINDOW)) div_rs_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("error %s expected %0h actual %0h", name, exp, act);
            $display("*** FAILED ***");
            $fatal(1, "Mismatch");
        end
    endtask

    task automatic add_row(input string name, input logic dv, input phys_reg_t s1,
                           input logic r1, input phys_reg_t s2, input logic r2,
                           input int bus, input logic wv, input phys_reg_t tag);
        row_t r;
        int   n;
        n      = table_rows.size();
        r.dv   = dv;
        r.pc   = 32'h8000_0000 + 32'(n * 4);
        r.rd   = 8'(n) + 8'h80;
        r.op   = 4'(n);
        r.src1 = s1;
        r.rdy1 = r1;
        r.src2 = s2;
        r.rdy2 = r2;
        r.bus  = bus;
        r.wv   = wv;
        r.tag  = tag;
        table_rows.push_back(r);
        table_names.push_back(name);
    endtask

    task automatic idle_rows(input string name, input int n);
        for (int i = 0; i < n; i++) begin
            add_row(name, 1'b0, 8'd0, 1'b0, 8'd0, 1'b0, 0, 1'b0, 8'd0);
        end
    endtask

    task automatic build_table();
        logic [31:0] x;
        idle_rows("reset_idle", 5);
        for (int i = 0; i < 4; i++) begin
            add_row("ready_order", 1'b1, 8'd1, 1'b1, 8'd2, 1'b1, 0, 1'b0, 8'd0);
        end
        idle_rows("ready_order", 6);
        for (int b = 0; b < 4; b++) begin
            add_row("bus_wakeup", 1'b1, 8'(10 + b), 1'b0, 8'd0, 1'b1, 0, 1'b0, 8'd0);
            add_row("bus_wakeup", 1'b0, 8'd0, 1'b0, 8'd0, 1'b0, b, 1'b0, 8'(10 + b));
            add_row("bus_wakeup", 1'b0, 8'd0, 1'b0, 8'd0, 1'b0, b, 1'b0, 8'(10 + b));
            add_row("bus_wakeup", 1'b0, 8'd0, 1'b0, 8'd0, 1'b0, b, 1'b1, 8'(10 + b));
            idle_rows("bus_wakeup", 3);
        end
        add_row("bypass", 1'b1, 8'd20, 1'b0, 8'd5, 1'b1, 2, 1'b1, 8'd20);
        idle_rows("bypass", 4);
        add_row("out_of_order", 1'b1, 8'd30, 1'b0, 8'd0, 1'b1, 0, 1'b0, 8'd0);
        add_row("out_of_order", 1'b1, 8'd1, 1'b1, 8'd2, 1'b1, 0, 1'b0, 8'd0);
        add_row("out_of_order", 1'b1, 8'd1, 1'b1, 8'd2, 1'b1, 0, 1'b0, 8'd0);
        idle_rows("out_of_order", 3);
        add_row("out_of_order", 1'b1, 8'd3, 1'b1, 8'd3, 1'b1, 1, 1'b1, 8'd30);
        idle_rows("out_of_order", 4);
        add_row("window", 1'b1, 8'd40, 1'b0, 8'd0, 1'b1, 0, 1'b0, 8'd0);
        for (int i = 0; i < 8; i++) begin
            add_row("window", 1'b1, 8'd41, 1'b0, 8'd0, 1'b1, 0, 1'b0, 8'd0);
        end
        add_row("window", 1'b1, 8'd1, 1'b1, 8'd2, 1'b1, 0, 1'b0, 8'd0);   // Past the window
        idle_rows("window", 4);
        add_row("window", 1'b0, 8'd0, 1'b0, 8'd0, 1'b0, 3, 1'b1, 8'd40);
        idle_rows("window", 2);
        add_row("window", 1'b0, 8'd0, 1'b0, 8'd0, 1'b0, 0, 1'b1, 8'd41);
        idle_rows("window", 12);
        x = 32'd20;
        for (int i = 0; i < 60; i++) begin
            x = xorshift(x);
            add_row("random", x[0], 8'(x[11:8]), x[1], 8'(x[15:12]), x[2],
                    int'(x[5:4]), x[3], 8'(x[19:16]));
        end
        for (int t = 0; t < 16; t++) begin
            add_row("drain", 1'b0, 8'd0, 1'b0, 8'd0, 1'b0, t % 4, 1'b1, 8'(t));
        end
        idle_rows("drain", 20);
    endtask

    // Advances the model by one clock edge
    task automatic model_step(input row_t r, input logic dv);
        logic found, adv;
        int   pick, idx;
        found = 1'b0;
        pick  = m_head;
        for (int k = 0; k < WINDOW; k++) begin
            idx = (m_head + k) % DEPTH;
            if (!found && m_occ[idx] && m_r1[idx] && m_r2[idx]) begin
                found = 1'b1;
                pick  = idx;
            end
        end
        adv = (found && pick == m_head) || m_iss[m_head];
        exp_valid = found;
        if (found) begin
            exp_pkt.pc   = m_pc[pick];
            exp_pkt.rd   = m_rd[pick];
            exp_pkt.op   = m_op[pick];
            exp_pkt.src1 = m_src1[pick];
            exp_pkt.src2 = m_src2[pick];
        end
        for (int i = 0; i < DEPTH; i++) begin
            if (m_occ[i] && !m_iss[i] && r.wv) begin
                if (m_src1[i] == r.tag) m_r1[i] = 1'b1;
                if (m_src2[i] == r.tag) m_r2[i] = 1'b1;
            end
        end
        if (found) begin
            m_r1[pick]  = 1'b0;
            m_r2[pick]  = 1'b0;
            m_iss[pick] = 1'b1;
        end
        if (adv) begin
            m_occ[m_head] = 1'b0;
            m_iss[m_head] = 1'b0;
            m_head  = (m_head + 1) % DEPTH;
            m_count = m_count - 1;
        end
        if (dv) begin
            m_occ[m_tail]  = 1'b1;
            m_iss[m_tail]  = 1'b0;
            m_r1[m_tail]   = r.rdy1 | (r.wv && r.tag == r.src1);   // Same-cycle bypass
            m_r2[m_tail]   = r.rdy2 | (r.wv && r.tag == r.src2);
            m_pc[m_tail]   = r.pc;
            m_rd[m_tail]   = r.rd;
            m_op[m_tail]   = r.op;
            m_src1[m_tail] = r.src1;
            m_src2[m_tail] = r.src2;
            m_tail  = (m_tail + 1) % DEPTH;
            m_count = m_count + 1;
            disp_count++;
        end
    endtask

    task automatic drive_row(input row_t r, input logic dv);
        dispatch_valid   = dv;
        dispatch_pc      = r.pc;
        dispatch_rd      = r.rd;
        dispatch_op      = r.op;
        dispatch_src1    = r.src1;
        dispatch_src2    = r.src2;
        dispatch_ready1  = r.rdy1;
        dispatch_ready2  = r.rdy2;
        alu_result_valid = r.wv && r.bus == 0;
        mul_result_valid = r.wv && r.bus == 1;
        div_result_valid = r.wv && r.bus == 2;
        load_read        = r.wv && r.bus == 3;
        alu_result_dest  = r.tag;
        mul_result_dest  = r.tag;
        div_result_dest  = r.tag;
        load_dest        = r.tag;
    endtask

    task automatic check_issue(input string name);
        check({name, " valid"}, 32'(exp_valid), 32'(issue_valid));
        if (exp_valid) begin
            check({name, " pc"}, exp_pkt.pc, issue_pc);
            check({name, " rd"}, 32'(exp_pkt.rd), 32'(issue_rd));
            check({name, " op"}, 32'(exp_pkt.op), 32'(issue_op));
            check({name, " src1"}, 32'(exp_pkt.src1), 32'(issue_src1));
            check({name, " src2"}, 32'(exp_pkt.src2), 32'(issue_src2));
            dut_issues++;
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Run did not finish within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        row_t blank;
        logic dv;
        cycles = 0;
        cycle_limit = 0;
        disp_count = 0;
        dut_issues = 0;
        m_head = 0;
        m_tail = 0;
        m_count = 0;
        exp_valid = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            m_occ[i] = 1'b0;
            m_iss[i] = 1'b0;
            m_r1[i]  = 1'b0;
            m_r2[i]  = 1'b0;
        end
        blank = '{default: 0};
        reset = 1'b1;
        drive_row(blank, 1'b0);
        build_table();
        cycle_limit = 2 * table_rows.size() + 100;
        repeat (10) @(posedge clk);
        #2 reset = 1'b0;
        foreach (table_rows[n]) begin
            @(posedge clk);
            #2;
            check_issue(table_names[n]);
            dv = table_rows[n].dv && (m_count < DEPTH);   // Never overfill
            drive_row(table_rows[n], dv);
            model_step(table_rows[n], dv);
        end
        @(posedge clk);
        #2;
        check_issue("final");
        check("all dispatched issued", 32'(disp_count), 32'(dut_issues));
        $display("*** PASSED ***");
        $finish;
    end

endmodule
